// File: src/bus_defines.svh
//~~~~~~~~~~~~~~~~~~~~
// bus slave sizes.
// word width, register address width and register count.
//~~~~~~~~~~~~~~~~~~~~

`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// host data word width.
`define BUS_WIDTH 32

// register address width.
`define REG_ADDR_BITS 4

// number of registers behind the slave.
`define REG_COUNT 16

`endif

// File: src/bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// bus slave package.
// word, address, command and state types for the slave.
//~~~~~~~~~~~~~~~~~~~~

`include "bus_defines.svh"

package bus_pkg;

	// one host data word.
	typedef logic [`BUS_WIDTH-1:0] bus_word_t;

	// register address.
	typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;

	// host read/write select.
	typedef enum logic {
		CMD_WRITE = 1'b0,
		CMD_READ  = 1'b1
	} bus_cmd_t;

	// control states of the slave machine.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ_ADDRESS,
		ST_GET_DATA,
		ST_SEND_DATA,
		ST_SEND_ACK,
		ST_WAIT_NREQ,
		ST_SEND_NACK
	} bus_state_t;

endpackage

// File: src/bus_fsm.sv
//~~~~~~~~~~~~~~~~~~~~
// bus_fsm
// moore control machine for the host bus slave.
// sequences each request and raises ack and datapath strobes.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bus_fsm (
	input  logic             clk,
	input  logic             reset,
	input  logic             req,
	input  bus_pkg::bus_cmd_t cmd,
	output logic             ack,
	output logic             addr_capture,
	output logic             store_word,
	output logic             fetch_word
);

	bus_pkg::bus_state_t state;
	bus_pkg::bus_state_t next_state;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= bus_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// next state.
	always_comb begin : set_next_state
		next_state = state;
		unique case (state)
			bus_pkg::ST_IDLE: begin
				if (req) begin
					next_state = bus_pkg::ST_READ_ADDRESS;
				end
			end
			bus_pkg::ST_READ_ADDRESS: begin
				if (cmd == bus_pkg::CMD_READ) begin
					next_state = bus_pkg::ST_SEND_DATA;
				end else begin
					next_state = bus_pkg::ST_GET_DATA;
				end
			end
			bus_pkg::ST_GET_DATA: begin
				next_state = bus_pkg::ST_SEND_ACK;
			end
			bus_pkg::ST_SEND_DATA: begin
				next_state = bus_pkg::ST_SEND_ACK;
			end
			bus_pkg::ST_SEND_ACK: begin
				next_state = bus_pkg::ST_WAIT_NREQ;
			end
			// park here until the host lets go of req.
			bus_pkg::ST_WAIT_NREQ: begin
				if (!req) begin
					next_state = bus_pkg::ST_SEND_NACK;
				end
			end
			bus_pkg::ST_SEND_NACK: begin
				next_state = bus_pkg::ST_IDLE;
			end
			default: begin
				next_state = bus_pkg::ST_IDLE;
			end
		endcase
	end : set_next_state

	// outputs from state only.
	always_comb begin : set_outputs
		case (state)
			bus_pkg::ST_READ_ADDRESS: begin
				ack          = 1'b0;
				addr_capture = 1'b1;
				store_word   = 1'b0;
				fetch_word   = 1'b0;
			end
			bus_pkg::ST_GET_DATA: begin
				ack          = 1'b1;
				addr_capture = 1'b0;
				store_word   = 1'b1;
				fetch_word   = 1'b0;
			end
			bus_pkg::ST_SEND_DATA: begin
				ack          = 1'b1;
				addr_capture = 1'b0;
				store_word   = 1'b0;
				fetch_word   = 1'b1;
			end
			// second ack cycle, word already stored or fetched.
			bus_pkg::ST_SEND_ACK: begin
				ack          = 1'b1;
				addr_capture = 1'b0;
				store_word   = 1'b0;
				fetch_word   = 1'b0;
			end
			bus_pkg::ST_WAIT_NREQ: begin
				ack          = 1'b0;
				addr_capture = 1'b0;
				store_word   = 1'b0;
				fetch_word   = 1'b0;
			end
			bus_pkg::ST_SEND_NACK: begin
				ack          = 1'b0;
				addr_capture = 1'b0;
				store_word   = 1'b0;
				fetch_word   = 1'b0;
			end
			default: begin
				ack          = 1'b0;
				addr_capture = 1'b0;
				store_word   = 1'b0;
				fetch_word   = 1'b0;
			end
		endcase
	end : set_outputs

endmodule

// File: src/bus_datapath.sv
//~~~~~~~~~~~~~~~~~~~~
// bus_datapath
// address latch, write path and output word register.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "bus_defines.svh"

module bus_datapath (
	input  logic               clk,
	input  logic               reset,
	input  bus_pkg::reg_addr_t addr,
	input  bus_pkg::bus_word_t wdata,
	input  logic               addr_capture,
	input  logic               store_word,
	input  logic               fetch_word,
	input  bus_pkg::bus_word_t rd_data,
	output logic               wr_en,
	output bus_pkg::reg_addr_t wr_addr,
	output bus_pkg::bus_word_t wr_data,
	output bus_pkg::reg_addr_t rd_addr,
	output bus_pkg::bus_word_t rdata
);

	bus_pkg::reg_addr_t addr_q;
	bus_pkg::bus_word_t rdata_q;

	// address latch.
	// loaded at the end of the address cycle, valid for the data cycle.
	always_ff @(posedge clk) begin
		if (addr_capture) begin
			addr_q <= addr;
		end
	end

	// write side to the register file.
	always_comb begin
		wr_en   = store_word;
		wr_addr = addr_q;
		wr_data = wdata;
	end

	// read side shares the latched address.
	assign rd_addr = addr_q;

	// output word register.
	// holds the last read word until the next read completes.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rdata_q <= {`BUS_WIDTH{1'b0}};
		end else if (fetch_word) begin
			rdata_q <= rd_data;
		end
	end

	assign rdata = rdata_q;

endmodule

// File: src/reg_file.sv
//~~~~~~~~~~~~~~~~~~~~
// reg_file
// register bank behind the slave.
// one synchronous write port, one combinational read port.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "bus_defines.svh"

module reg_file (
	input  logic               clk,
	input  logic               reset,
	input  logic               wr_en,
	input  bus_pkg::reg_addr_t wr_addr,
	input  bus_pkg::bus_word_t wr_data,
	input  bus_pkg::reg_addr_t rd_addr,
	output bus_pkg::bus_word_t rd_data
);

	bus_pkg::bus_word_t regs [`REG_COUNT];

	// all registers read zero after reset.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// zero latency read.
	assign rd_data = regs[rd_addr];

endmodule

// File: src/bus_slave_top.sv
//~~~~~~~~~~~~~~~~~~~~
// bus_slave_top
// host bus register slave.
// control machine, datapath and register file.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bus_slave_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               req,
	input  bus_pkg::bus_cmd_t  cmd,
	input  bus_pkg::reg_addr_t addr,
	input  bus_pkg::bus_word_t wdata,
	output logic               ack,
	output bus_pkg::bus_word_t rdata
);

	// strobes from the control machine.
	logic addr_capture;
	logic store_word;
	logic fetch_word;

	// register file ports.
	logic               wr_en;
	bus_pkg::reg_addr_t wr_addr;
	bus_pkg::bus_word_t wr_data;
	bus_pkg::reg_addr_t rd_addr;
	bus_pkg::bus_word_t rd_data;

	bus_fsm u_fsm (
		.clk          (clk),
		.reset        (reset),
		.req          (req),
		.cmd          (cmd),
		.ack          (ack),
		.addr_capture (addr_capture),
		.store_word   (store_word),
		.fetch_word   (fetch_word)
	);

	bus_datapath u_datapath (
		.clk          (clk),
		.reset        (reset),
		.addr         (addr),
		.wdata        (wdata),
		.addr_capture (addr_capture),
		.store_word   (store_word),
		.fetch_word   (fetch_word),
		.rd_data      (rd_data),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.rd_addr      (rd_addr),
		.rdata        (rdata)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// File: tests/bus_slave_sva.sv
//~~~~~~~~~~~~~~~~~~~~
// bus_slave_sva
// strobe and ack timing checks bound to the control machine.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bus_slave_sva (
	input logic                clk,
	input logic                reset,
	input logic                req,
	input logic                ack,
	input logic                addr_capture,
	input logic                store_word,
	input logic                fetch_word,
	input bus_pkg::bus_state_t state
);

	// store and fetch never share a cycle.
	strobe_exclusive: assert property (
		@(posedge clk) disable iff (!reset) !(store_word && fetch_word)
	) else $error("store_word and fetch_word high in the same cycle");

	// ack pulse is exactly two cycles long.
	ack_two_cycles: assert property (
		@(posedge clk) disable iff (!reset) $rose(ack) |=> ack ##1 !ack
	) else $error("ack pulse is not two cycles long");

	// request seen in idle, ack follows two cycles later.
	ack_after_req: assert property (
		@(posedge clk) disable iff (!reset)
		(state == bus_pkg::ST_IDLE && req) |-> ##2 $rose(ack)
	) else $error("ack did not rise two cycles after the request");

	reset_quiet: assert property (
		@(posedge clk) !reset |-> !(ack || addr_capture || store_word || fetch_word)
	) else $error("strobe or ack high during reset");

endmodule

bind bus_fsm bus_slave_sva u_sva (
	.clk          (clk),
	.reset        (reset),
	.req          (req),
	.ack          (ack),
	.addr_capture (addr_capture),
	.store_word   (store_word),
	.fetch_word   (fetch_word),
	.state        (state)
);

// File: tests/bus_slave_tb.sv
//~~~~~~~~~~~~~~~~~~~~
// bus_slave_tb
// table driven testbench for the host bus register slave.
// host model, reference registers and result report.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "bus_defines.svh"

module bus_slave_tb;

	localparam int TABLE_LEN    = 53;
	localparam int RANDOM_COUNT = 40;
	localparam int RISE_TIMEOUT = 16;
	localparam int FALL_TIMEOUT = 8;

	logic               clk;
	logic               reset;
	logic               req;
	bus_pkg::bus_cmd_t  cmd;
	bus_pkg::reg_addr_t addr;
	bus_pkg::bus_word_t wdata;
	logic               ack;
	bus_pkg::bus_word_t rdata;

	// transaction table, one column per field.
	bus_pkg::bus_cmd_t  tbl_cmd   [TABLE_LEN];
	bus_pkg::reg_addr_t tbl_addr  [TABLE_LEN];
	bus_pkg::bus_word_t tbl_wdata [TABLE_LEN];
	int                 tbl_hold  [TABLE_LEN];
	bus_pkg::bus_word_t tbl_exp   [TABLE_LEN];
	bit                 tbl_ref   [TABLE_LEN];
	int                 n_entries;

	// reference copy of the register file.
	bus_pkg::bus_word_t ref_regs [`REG_COUNT];
	bus_pkg::bus_word_t last_read;

	int          pass_count;
	int          fail_count;
	int          fails_before;
	bit          timed_out;
	int unsigned seed_ret;

	bus_slave_top UUT (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.cmd   (cmd),
		.addr  (addr),
		.wdata (wdata),
		.ack   (ack),
		.rdata (rdata)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic add_entry(input bus_pkg::bus_cmd_t c, input bus_pkg::reg_addr_t a,
		input bus_pkg::bus_word_t d, input int hold, input bus_pkg::bus_word_t e,
		input bit from_ref);
		tbl_cmd[n_entries]   = c;
		tbl_addr[n_entries]  = a;
		tbl_wdata[n_entries] = d;
		tbl_hold[n_entries]  = hold;
		tbl_exp[n_entries]   = e;
		tbl_ref[n_entries]   = from_ref;
		n_entries++;
	endtask

	task automatic build_table();
		bus_pkg::bus_cmd_t  c;
		bus_pkg::reg_addr_t a;
		// fresh registers read zero.
		add_entry(bus_pkg::CMD_READ,  4'd0,  32'h0, 0, 32'h0, 1'b0);
		add_entry(bus_pkg::CMD_READ,  4'd7,  32'h0, 0, 32'h0, 1'b0);
		add_entry(bus_pkg::CMD_READ,  4'd15, 32'h0, 0, 32'h0, 1'b0);
		add_entry(bus_pkg::CMD_WRITE, 4'd3,  32'hdead_beef, 0, 32'h0, 1'b0);
		add_entry(bus_pkg::CMD_WRITE, 4'd9,  32'h1234_5678, 1, 32'h0, 1'b0);
		add_entry(bus_pkg::CMD_READ,  4'd3,  32'h0, 0, 32'hdead_beef, 1'b0);
		add_entry(bus_pkg::CMD_READ,  4'd9,  32'h0, 2, 32'h1234_5678, 1'b0);
		// overwrite, neighbour must survive.
		add_entry(bus_pkg::CMD_WRITE, 4'd3,  32'ha5a5_5a5a, 0, 32'h0, 1'b0);
		add_entry(bus_pkg::CMD_READ,  4'd3,  32'h0, 0, 32'ha5a5_5a5a, 1'b0);
		add_entry(bus_pkg::CMD_READ,  4'd9,  32'h0, 0, 32'h1234_5678, 1'b0);
		// long holds on req.
		add_entry(bus_pkg::CMD_READ,  4'd9,  32'h0, 20, 32'h1234_5678, 1'b0);
		add_entry(bus_pkg::CMD_WRITE, 4'd5,  32'h0f0f_0f0f, 25, 32'h0, 1'b0);
		add_entry(bus_pkg::CMD_READ,  4'd5,  32'h0, 0, 32'h0f0f_0f0f, 1'b0);
		// even entries sweep the addresses, odd ones pick at random.
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			c = ($urandom_range(0, 1) == 1) ? bus_pkg::CMD_READ : bus_pkg::CMD_WRITE;
			if (i % 2 == 0) begin
				a = bus_pkg::reg_addr_t'((i / 2) % `REG_COUNT);
			end else begin
				a = bus_pkg::reg_addr_t'($urandom_range(0, `REG_COUNT - 1));
			end
			add_entry(c, a, $urandom, $urandom_range(0, 3), 32'h0, 1'b1);
		end
	endtask

	task automatic check_word(input bus_pkg::reg_addr_t a, input bus_pkg::bus_word_t got,
		input bus_pkg::bus_word_t exp);
		if (got !== exp) begin
			$display("ERROR %0t: addr %0d got %h expected %h", $time, a, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_ack_len(input int cycles);
		if (cycles != 2) begin
			$display("ERROR %0t: ack high for %0d cycles, expected 2", $time, cycles);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_ack_level(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t: ack is %b, expected %b", $time, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// host model, one full handshake per call, entered just after a falling edge.
	task automatic run_transaction(input int idx);
		int                 waited;
		int                 ack_cycles;
		bus_pkg::bus_word_t exp;
		cmd        = tbl_cmd[idx];
		addr       = tbl_addr[idx];
		wdata      = tbl_wdata[idx];
		req        = 1'b1;
		waited     = 0;
		ack_cycles = 0;
		while (ack !== 1'b1 && waited < RISE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (ack !== 1'b1) begin
			$display("entry %0d: ack never rose", idx);
			timed_out = 1'b1;
			req = 1'b0;
			return;
		end
		waited = 0;
		while (ack === 1'b1 && waited < FALL_TIMEOUT) begin
			ack_cycles++;
			@(negedge clk);
			waited++;
		end
		if (ack === 1'b1) begin
			$display("entry %0d: ack never fell", idx);
			timed_out = 1'b1;
			req = 1'b0;
			return;
		end
		// a second store while req is held would write a different word.
		wdata = ~tbl_wdata[idx];
		// any second pulse while req is held shows up in the count.
		repeat (tbl_hold[idx]) begin
			@(negedge clk);
			if (ack === 1'b1) begin
				ack_cycles++;
			end
		end
		req = 1'b0;
		// two low cycles bring the machine back to idle.
		repeat (2) begin
			@(negedge clk);
			if (ack === 1'b1) begin
				ack_cycles++;
			end
		end
		check_ack_len(ack_cycles);
		if (tbl_cmd[idx] == bus_pkg::CMD_WRITE) begin
			ref_regs[tbl_addr[idx]] = tbl_wdata[idx];
			// a write leaves the output word alone.
			check_word(tbl_addr[idx], rdata, last_read);
		end else begin
			exp = tbl_ref[idx] ? ref_regs[tbl_addr[idx]] : tbl_exp[idx];
			check_word(tbl_addr[idx], rdata, exp);
			last_read = exp;
		end
	endtask

	initial begin
		reset      = 1'b0;
		req        = 1'b0;
		cmd        = bus_pkg::CMD_WRITE;
		addr       = '0;
		wdata      = '0;
		pass_count = 0;
		fail_count = 0;
		timed_out  = 1'b0;
		n_entries  = 0;
		last_read  = '0;
		seed_ret   = $urandom(32'h8dc1_ee6b);
		for (int i = 0; i < `REG_COUNT; i++) begin
			ref_regs[i] = '0;
		end
		build_table();
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		check_word('0, rdata, '0);
		check_ack_level(ack, 1'b0);
		for (int i = 0; i < n_entries && !timed_out; i++) begin
			fails_before = fail_count;
			run_transaction(i);
			if (!timed_out) begin
				$display("entry %0d: %s addr %0d: %s", i,
					(tbl_cmd[i] == bus_pkg::CMD_READ) ? "read " : "write",
					tbl_addr[i], (fail_count == fails_before) ? "ok" : "mismatch");
			end
		end
		$display("summary: %0d checks ok, %0d checks wrong", pass_count, fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+src
src/bus_pkg.sv
src/bus_fsm.sv
src/bus_datapath.sv
src/reg_file.sv
src/bus_slave_top.sv
tests/bus_slave_sva.sv
tests/bus_slave_tb.sv
